// ==== hdl/sdramCtrl_settings.svh ====
// SDRAM burst controller settings
// Widths, FIFO depth and SDRAM timing shared by the whole controller
`ifndef SDRAMCTRL_SETTINGS_SVH
`define SDRAMCTRL_SETTINGS_SVH

// Data and address widths
`define DSIZE 16 // Data word
`define ASIZE 22 // Word address, bank/row/column from the top
`define ROWW 12
`define COLW 8
`define BANKW 2
`define LENW 4 // Burst length 1..8

// Port FIFOs
`define FIFO_DEPTH 16 // Power of two
`define FIFO_CNTW ($clog2(`FIFO_DEPTH) + 1) // Fill count, holds 0..DEPTH

// SDRAM timing in cycles
`define SC_CL 2 // CAS latency
`define SC_RCD 2 // ACTIVE to READ/WRITE

// Burst length held by every port until its first load
`define RESET_LEN 1

`endif

// ==== hdl/sdramPkg.sv ====
// SDRAM controller types
// Data word, port load bundle, SDRAM command codes and pin bundle
`include "sdramCtrl_settings.svh"
`default_nettype none

package sdramPkg;

	typedef logic [`DSIZE-1:0] dataWord_t;

	// Load bundle of one host port
	typedef struct packed {
		logic [`ASIZE-1:0] start; // Window start
		logic [`ASIZE-1:0] max; // Window end, pointer wraps here
		logic [`LENW-1:0] length; // Words per burst
	} portCfg_t;

	// {RAS_N, CAS_N, WE_N}
	typedef enum logic [2:0] {
		NOP = 3'b111,
		ACTIVE = 3'b011,
		READ = 3'b101,
		WRITE = 3'b100,
		BURST_TERM = 3'b110,
		PRECHARGE = 3'b010
	} sdrCmd_t;

	// Registered SDRAM pins
	typedef struct packed {
		sdrCmd_t cmd;
		logic [`BANKW-1:0] bank;
		logic [`ROWW-1:0] addr; // Row on ACTIVE, column on READ/WRITE
		logic [1:0] dqm; // Byte masks, active high
	} sdrBus_t;

	// Burst picked by the arbiter
	typedef struct packed {
		logic [`ASIZE-1:0] addr;
		logic [`LENW-1:0] length;
		logic isWrite;
	} burstReq_t;

endpackage

`default_nettype wire

// ==== hdl/portFifo.sv ====
// Port FIFO
// Single-clock circular buffer between a host port and the burst engine,
// with full and empty flags and a fill count for arbitration
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"
`default_nettype none

module portFifo (
	input wire logic CLK,
	input wire logic RESET_N,
	input wire logic clear, // Port load, drops all contents
	input wire logic push,
	input wire sdramPkg::dataWord_t pushData,
	input wire logic pop,
	output sdramPkg::dataWord_t popData, // Head word, valid while not empty
	output logic full,
	output logic empty,
	output logic [`FIFO_CNTW-1:0] count
);

	localparam int AW = $clog2(`FIFO_DEPTH);

	sdramPkg::dataWord_t mem [`FIFO_DEPTH];
	logic [AW-1:0] wrPtr; // Next free slot
	logic [AW-1:0] rdPtr; // Head slot

	// Pointers and count
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1; // Wraps at depth
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (push && !clear)
			mem[wrPtr] <= pushData;
	end

	assign popData = mem[rdPtr]; // Show-ahead
	assign full = (count == `FIFO_DEPTH);
	assign empty = (count == 0);

	// Host and burst engine both respect the flags
	assert property (@(posedge CLK) disable iff (!RESET_N) push |-> !full)
		else $error("push into full port FIFO");
	assert property (@(posedge CLK) disable iff (!RESET_N) pop |-> !empty)
		else $error("pop from empty port FIFO");

endmodule

`default_nettype wire

// ==== hdl/burstAddress.sv ====
// Burst address walker
// Per-port SDRAM pointer, advanced by one burst length after each burst
// and wrapped back to the window start at the window end
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"
`default_nettype none

module burstAddress (
	input wire logic CLK,
	input wire logic RESET_N,
	input wire logic load, // Host reload of the window
	input wire sdramPkg::portCfg_t cfg,
	input wire logic done, // Burst of this port finished
	output logic [`ASIZE-1:0] addr,
	output logic [`LENW-1:0] length
);

	logic [`ASIZE-1:0] ptr;
	logic [`ASIZE-1:0] startAddr; // Start taken at last load
	logic [`ASIZE-1:0] maxAddr;
	logic [`LENW-1:0] len;
	logic [`ASIZE-1:0] nextAddr;

	assign nextAddr = ptr + `ASIZE'(len);

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			ptr <= '0;
			startAddr <= '0;
			maxAddr <= '0;
			len <= `LENW'(`RESET_LEN);
		end
		else if (load) // Load wins over a finishing burst
		begin
			ptr <= cfg.start;
			startAddr <= cfg.start;
			maxAddr <= cfg.max;
			len <= cfg.length;
		end
		else if (done)
			ptr <= (nextAddr >= maxAddr) ? startAddr : nextAddr; // Wrap at window end
	end

	assign addr = ptr;
	assign length = len;

	// Pointer stays inside the window after every step
	assert property (@(posedge CLK) disable iff (!RESET_N)
		done |=> (ptr >= startAddr) && (ptr <= maxAddr))
		else $error("burst pointer left its window");

endmodule

`default_nettype wire

// ==== hdl/burstControl.sv ====
// Burst controller
// Fixed-priority arbiter over two write and two read ports, and the step
// counter that walks one full-page burst through ACTIVE, READ/WRITE,
// BURST TERMINATE and PRECHARGE
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"
`default_nettype none

module burstControl (
	input wire logic CLK,
	input wire logic RESET_N,
	input wire logic anyLoad, // Holds off new grants
	input wire logic [1:0][`FIFO_CNTW-1:0] wrCount,
	input wire logic [1:0][`FIFO_CNTW-1:0] rdCount,
	input wire logic [3:0][`ASIZE-1:0] addr, // Port order wr0, wr1, rd0, rd1
	input wire logic [3:0][`LENW-1:0] length,
	output sdramPkg::sdrCmd_t cmd,
	output sdramPkg::burstReq_t req,
	output logic [1:0] wrPop,
	output logic [1:0] rdPush,
	output logic driveDq,
	output logic [3:0] done
);

	localparam int STEPW = `LENW + 2;
	localparam logic [STEPW-1:0] RCD = STEPW'(`SC_RCD);
	localparam logic [STEPW-1:0] CL = STEPW'(`SC_CL);

	logic busy;
	logic [3:0] grant; // One-hot port being served
	logic [STEPW-1:0] step; // 0 is the grant cycle
	logic [STEPW-1:0] len;
	logic [STEPW-1:0] termStep; // BURST_TERM step
	logic [3:0] eligible;
	logic [1:0] pick;
	logic found;
	logic wrWin; // Write data steps
	logic rdWin; // Read capture steps

	// Eligibility per port
	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			eligible[i] = (wrCount[i] >= length[i]) && (length[i] != '0); // Full burst queued
			// Room for a full burst and a nonzero length
			eligible[i+2] = ((`FIFO_DEPTH - rdCount[i]) >= length[i+2]) && (length[i+2] != '0);
		end
	end

	// Lowest index wins
	always_comb
	begin
		pick = '0;
		found = 1'b0;
		for (int i = 3; i >= 0; i--)
		begin
			if (eligible[i])
			begin
				pick = 2'(i);
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			busy <= 1'b0;
			grant <= '0;
			step <= '0;
			req <= '0;
		end
		else if (!busy)
		begin
			if (found && !anyLoad)
			begin
				busy <= 1'b1;
				grant <= 4'b0001 << pick;
				step <= '0;
				req.addr <= addr[pick];
				req.length <= length[pick];
				req.isWrite <= !pick[1]; // Ports 0 and 1 write
			end
		end
		else if (step == termStep + 2'd2) // Done step then idle
		begin
			busy <= 1'b0;
			grant <= '0;
		end
		else
			step <= step + 1'b1;
	end

	assign len = STEPW'(req.length);
	assign termStep = req.isWrite ? RCD + len : RCD + CL + len;

	// Command per step
	always_comb
	begin
		cmd = sdramPkg::NOP;
		if (busy)
		begin
			if (step == '0)
				cmd = sdramPkg::ACTIVE;
			else if (step == RCD)
				cmd = req.isWrite ? sdramPkg::WRITE : sdramPkg::READ;
			else if (step == termStep)
				cmd = sdramPkg::BURST_TERM;
			else if (step == termStep + 1'b1)
				cmd = sdramPkg::PRECHARGE;
		end
	end

	assign wrWin = busy && req.isWrite && (step >= RCD) && (step < RCD + len);
	// Word on DQ at RCD+CL is captured by the pin stage and pushed a cycle later
	assign rdWin = busy && !req.isWrite && (step > RCD + CL) && (step <= RCD + CL + len);

	assign wrPop = grant[1:0] & {2{wrWin}};
	assign rdPush = grant[3:2] & {2{rdWin}};
	assign driveDq = wrWin;
	assign done = grant & {4{busy && (step == termStep + 2'd2)}};

	// Grant goes to the lowest eligible port only
	assert property (@(posedge CLK) disable iff (!RESET_N)
		(!busy && found && !anyLoad) |=> (grant == $past(eligible & (~eligible + 4'd1))))
		else $error("burst grant is not the first eligible port");
	// Two idle cycles after PRECHARGE before the next ACTIVE
	assert property (@(posedge CLK) disable iff (!RESET_N)
		(cmd == sdramPkg::PRECHARGE) |=> (cmd == sdramPkg::NOP) ##1 (cmd == sdramPkg::NOP))
		else $error("SDRAM command overlaps previous burst");

endmodule

`default_nettype wire

// ==== hdl/sdramPhy.sv ====
// SDRAM pin stage
// Registers command, bank, address and DQM one cycle after each step,
// drives DQ during write data and samples DQ every cycle for reads
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"
`default_nettype none

module sdramPhy (
	input wire logic CLK,
	input wire logic RESET_N,
	input wire sdramPkg::sdrCmd_t cmd,
	input wire sdramPkg::burstReq_t req,
	input wire logic driveDq, // Write data step
	input wire sdramPkg::dataWord_t wrWord,
	output sdramPkg::sdrBus_t pins,
	inout wire sdramPkg::dataWord_t DQ,
	output sdramPkg::dataWord_t rdWord // DQ one cycle late
);

	logic [`BANKW-1:0] bank;
	logic [`ROWW-1:0] row;
	logic [`COLW-1:0] col;
	logic readOpen; // Between READ and BURST_TERM
	logic dqOe;
	sdramPkg::dataWord_t dqOut;

	// Bank, row, column from the top of the address
	assign {bank, row, col} = req.addr;

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pins.cmd <= sdramPkg::NOP;
			pins.bank <= '0;
			pins.addr <= '0;
			pins.dqm <= 2'b11; // Masked
			dqOe <= 1'b0;
			readOpen <= 1'b0;
		end
		else
		begin
			pins.cmd <= cmd;
			pins.bank <= bank;
			pins.addr <= (cmd == sdramPkg::ACTIVE) ? row : `ROWW'(col); // A10 low, no auto precharge
			pins.dqm <= (driveDq || readOpen) ? 2'b00 : 2'b11;
			dqOe <= driveDq;
			if (cmd == sdramPkg::READ)
				readOpen <= 1'b1;
			else if (cmd == sdramPkg::BURST_TERM)
				readOpen <= 1'b0;
		end
	end

	// Data path
	always_ff @(posedge CLK)
	begin
		if (driveDq)
			dqOut <= wrWord;
		rdWord <= DQ;
	end

	assign DQ = dqOe ? dqOut : 'z;

endmodule

`default_nettype wire

// ==== hdl/sdramPortCtrl.sv ====
// SDRAM port controller top
// Two write and two read host ports, each with a FIFO and an address
// walker, sharing one SDRAM through the burst controller and pin stage
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"
`default_nettype none

module sdramPortCtrl (
	input wire logic CLK,
	input wire logic RESET_N,
	input wire sdramPkg::portCfg_t [1:0] wrCfg, // Write windows
	input wire logic [1:0] wrLoad,
	input wire sdramPkg::dataWord_t [1:0] wrData,
	input wire logic [1:0] wr,
	output logic [1:0] wrFull,
	input wire sdramPkg::portCfg_t [1:0] rdCfg, // Read windows
	input wire logic [1:0] rdLoad,
	input wire logic [1:0] rd,
	output sdramPkg::dataWord_t [1:0] rdData,
	output logic [1:0] rdEmpty,
	output sdramPkg::sdrBus_t pins,
	inout wire sdramPkg::dataWord_t DQ
);

	logic [1:0][`FIFO_CNTW-1:0] wrCount;
	logic [1:0][`FIFO_CNTW-1:0] rdCount;
	logic [3:0][`ASIZE-1:0] portAddr; // wr0, wr1, rd0, rd1
	logic [3:0][`LENW-1:0] portLen;
	logic [3:0] done;
	logic [1:0] wrPop;
	logic [1:0] rdPush;
	logic anyLoad;
	logic driveDq;
	sdramPkg::dataWord_t [1:0] wrWord; // FIFO heads
	sdramPkg::dataWord_t wrSel;
	sdramPkg::dataWord_t rdWord;
	sdramPkg::sdrCmd_t cmd;
	sdramPkg::burstReq_t req;

	assign anyLoad = |{wrLoad, rdLoad};
	assign wrSel = wrPop[1] ? wrWord[1] : wrWord[0]; // Popping FIFO

	for (genvar i = 0; i < 2; i++)
	begin : genPort
		portFifo wrFifo (.CLK, .RESET_N, .clear(wrLoad[i]), .push(wr[i]), .pushData(wrData[i]),
			.pop(wrPop[i]), .popData(wrWord[i]), .full(wrFull[i]), .empty(), .count(wrCount[i]));
		portFifo rdFifo (.CLK, .RESET_N, .clear(rdLoad[i]), .push(rdPush[i]), .pushData(rdWord),
			.pop(rd[i]), .popData(rdData[i]), .full(), .empty(rdEmpty[i]), .count(rdCount[i]));
		burstAddress wrAddr (.CLK, .RESET_N, .load(wrLoad[i]), .cfg(wrCfg[i]), .done(done[i]),
			.addr(portAddr[i]), .length(portLen[i]));
		burstAddress rdAddr (.CLK, .RESET_N, .load(rdLoad[i]), .cfg(rdCfg[i]), .done(done[i+2]),
			.addr(portAddr[i+2]), .length(portLen[i+2]));
	end

	burstControl control (.CLK, .RESET_N, .anyLoad, .wrCount, .rdCount, .addr(portAddr),
		.length(portLen), .cmd, .req, .wrPop, .rdPush, .driveDq, .done);

	sdramPhy phy (.CLK, .RESET_N, .cmd, .req, .driveDq, .wrWord(wrSel), .pins, .DQ, .rdWord);

endmodule

`default_nettype wire

// ==== dv/sdramModel.sv ====
// Behavioral SDRAM
// Decodes the registered command pins, keeps one open row per bank and
// stores full-page burst data in a sparse memory
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"
`default_nettype none

module sdramModel (
	input wire logic CLK,
	input wire sdramPkg::sdrBus_t pins,
	inout wire sdramPkg::dataWord_t DQ
);

	sdramPkg::dataWord_t mem [logic [`ASIZE-1:0]]; // Written words only
	logic [`ROWW-1:0] openRow [1 << `BANKW];
	logic [`BANKW-1:0] curBank;
	logic [`COLW-1:0] col; // Next column of the open burst
	logic writing = 1'b0;
	logic reading = 1'b0;
	logic dqOe = 1'b0;
	sdramPkg::dataWord_t dqOut;

	// Unwritten locations read as zero
	function automatic sdramPkg::dataWord_t readWord(input logic [`ASIZE-1:0] a);
		return mem.exists(a) ? mem[a] : '0;
	endfunction

	// A high DQM bit keeps the old byte
	function automatic void storeWord(input logic [`ASIZE-1:0] a,
		input sdramPkg::dataWord_t w, input logic [1:0] m);
		sdramPkg::dataWord_t merged;
		merged = readWord(a);
		if (!m[0])
			merged[7:0] = w[7:0];
		if (!m[1])
			merged[15:8] = w[15:8];
		mem[a] = merged;
	endfunction

	always @(posedge CLK)
	begin
		case (pins.cmd)
			sdramPkg::ACTIVE:
				openRow[pins.bank] <= pins.addr;
			sdramPkg::WRITE:
			begin
				// First word with command
				storeWord({pins.bank, openRow[pins.bank], pins.addr[`COLW-1:0]}, DQ, pins.dqm);
				curBank <= pins.bank;
				col <= pins.addr[`COLW-1:0] + 1'b1;
				writing <= 1'b1;
			end
			sdramPkg::READ:
			begin
				// Pin stage samples one cycle late, so data goes out right after the command
				dqOut <= readWord({pins.bank, openRow[pins.bank], pins.addr[`COLW-1:0]});
				dqOe <= 1'b1;
				curBank <= pins.bank;
				col <= pins.addr[`COLW-1:0] + 1'b1;
				reading <= 1'b1;
			end
			sdramPkg::BURST_TERM:
			begin
				writing <= 1'b0;
				reading <= 1'b0;
				dqOe <= 1'b0; // Release bus
			end
			default:
			begin
				if (writing)
				begin
					storeWord({curBank, openRow[curBank], col}, DQ, pins.dqm);
					col <= col + 1'b1; // Page wrap like a full-page burst
				end
				else if (reading)
				begin
					dqOut <= readWord({curBank, openRow[curBank], col});
					col <= col + 1'b1;
				end
			end
		endcase
	end

	assign DQ = dqOe ? dqOut : 'z;

endmodule

`default_nettype wire

// ==== dv/tbSdramPortCtrl.sv ====
// Testbench for the SDRAM port controller
// Random host traffic on two write and two read ports, checked against a
// reference memory and per-port pointer models
`timescale 1ns/1ps
`include "sdramCtrl_settings.svh"
`default_nettype none

module tbSdramPortCtrl;

	localparam int BURST = 8; // Length loaded into every active port
	localparam int TIMEOUT = 4 * 64 * 20; // Tests x bursts x cycles
	localparam logic [`ASIZE-1:0] WIN0 = 22'h000100; // Bank 0 row 1
	localparam logic [`ASIZE-1:0] WIN1 = 22'h100400; // Bank 1 row 4
	localparam logic [`ASIZE-1:0] RELOAD_START = 22'h000200;

	logic CLK;
	logic RESET_N;
	sdramPkg::portCfg_t [1:0] wrCfg;
	logic [1:0] wrLoad;
	sdramPkg::dataWord_t [1:0] wrData;
	logic [1:0] wr;
	logic [1:0] wrFull;
	sdramPkg::portCfg_t [1:0] rdCfg;
	logic [1:0] rdLoad;
	logic [1:0] rd;
	sdramPkg::dataWord_t [1:0] rdData;
	logic [1:0] rdEmpty;
	sdramPkg::sdrBus_t pins;
	wire sdramPkg::dataWord_t dq;

	sdramPkg::dataWord_t expMem [logic [`ASIZE-1:0]]; // Expected SDRAM contents
	logic [`ASIZE-1:0] ptrM [4]; // Pointer model in order wr0 wr1 rd0 rd1
	logic [`ASIZE-1:0] startM [4];
	logic [`ASIZE-1:0] maxM [4];
	int idxM [4]; // Word within current burst
	string testName;
	int errors = 0;
	int rdChecked = 0;
	int memChecked = 0;
	int cycles;
	logic [31:0] rngState = 32'd40708;
	logic burstSeen = 1'b0;

	sdramPortCtrl dut0 (.CLK, .RESET_N, .wrCfg, .wrLoad, .wrData, .wr, .wrFull, .rdCfg,
		.rdLoad, .rd, .rdData, .rdEmpty, .pins, .DQ(dq));

	sdramModel mem0 (.CLK, .pins, .DQ(dq));

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic sdramPkg::portCfg_t makeCfg(input logic [`ASIZE-1:0] start,
		input int span, input int len);
		sdramPkg::portCfg_t c;
		c.start = start;
		c.max = start + `ASIZE'(span); // Window of span words
		c.length = `LENW'(len);
		return c;
	endfunction

	task automatic loadModel(input int p, input sdramPkg::portCfg_t c);
		ptrM[p] = c.start;
		startM[p] = c.start;
		maxM[p] = c.max;
		idxM[p] = 0;
	endtask

	// One word further and after a full burst the pointer jumps or wraps
	task automatic stepModel(input int p);
		logic [`ASIZE-1:0] nextPtr;
		idxM[p]++;
		if (idxM[p] == BURST)
		begin
			idxM[p] = 0;
			nextPtr = ptrM[p] + `ASIZE'(BURST);
			ptrM[p] = (nextPtr >= maxM[p]) ? startM[p] : nextPtr;
		end
	endtask

	task automatic recordWrite(input int p, input sdramPkg::dataWord_t w);
		expMem[ptrM[p] + `ASIZE'(idxM[p])] = w;
		stepModel(p);
	endtask

	task automatic checkRead(input int p, input sdramPkg::dataWord_t got);
		logic [`ASIZE-1:0] a;
		a = ptrM[p+2] + `ASIZE'(idxM[p+2]);
		rdChecked++;
		if (got !== expMem[a])
		begin
			$display("ERROR %s: rd%0d addr %h expected %h, actual %h",
				testName, p, a, expMem[a], got);
			errors++;
		end
		stepModel(p + 2);
	endtask

	// Random strobes at most once per port every two cycles so the flags stay current
	task automatic exchange(input int wrN0, input int wrN1, input int rdN0, input int rdN1);
		int left [4];
		logic [31:0] r;
		logic [1:0] wrNext;
		logic [1:0] rdNext;
		sdramPkg::dataWord_t [1:0] word;
		left[0] = wrN0;
		left[1] = wrN1;
		left[2] = rdN0;
		left[3] = rdN1;
		while ((left[0] + left[1] + left[2] + left[3]) > 0)
		begin
			@(negedge CLK); // Flags and head words settled
			rngState = xorshift32(rngState);
			r = rngState;
			wrNext = '0;
			rdNext = '0;
			word[0] = r[31:16];
			word[1] = r[23:8];
			for (int p = 0; p < 2; p++)
			begin
				if ((left[p] > 0) && !wrFull[p] && r[p])
				begin
					wrNext[p] = 1'b1;
					recordWrite(p, word[p]);
					left[p]--;
				end
				if ((left[p+2] > 0) && !rdEmpty[p] && r[p+2])
				begin
					rdNext[p] = 1'b1;
					checkRead(p, rdData[p]); // Head word popped below
					left[p+2]--;
				end
			end
			@(posedge CLK);
			wrData <= word;
			wr <= wrNext;
			rd <= rdNext;
			@(posedge CLK);
			wr <= '0;
			rd <= '0;
		end
	endtask

	// Bursts have NOP runs shorter than this
	task automatic waitIdle();
		int quiet;
		quiet = 0;
		while (quiet < 16)
		begin
			@(negedge CLK);
			if (pins.cmd == sdramPkg::NOP)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic checkMemory();
		sdramPkg::dataWord_t got;
		foreach (expMem[a])
		begin
			got = mem0.readWord(a);
			memChecked++;
			if (got !== expMem[a])
			begin
				$display("ERROR %s: addr %h expected %h, actual %h", testName, a, expMem[a], got);
				errors++;
			end
		end
	endtask

	// Idle pins and flags until the first ACTIVE
	always @(negedge CLK)
	begin
		if (!burstSeen)
		begin
			if (pins.cmd == sdramPkg::ACTIVE)
				burstSeen = 1'b1;
			else
			begin
				if ((pins.cmd !== sdramPkg::NOP) || (pins.dqm !== 2'b11))
				begin
					$display("ERROR reset: expected cmd %b dqm 11, actual cmd %b dqm %b",
						sdramPkg::NOP, pins.cmd, pins.dqm);
					errors++;
				end
				if ((rdEmpty !== 2'b11) || (wrFull !== 2'b00))
				begin
					$display("ERROR reset: expected rdEmpty 11 wrFull 00, actual %b %b",
						rdEmpty, wrFull);
					errors++;
				end
			end
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT)
		begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timeout: test %s still running after %0d cycles", testName, cycles);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		testName = "reset";
		RESET_N = 1'b0;
		wr = '0;
		rd = '0;
		wrData = '0;
		wrLoad = 2'b11; // Loads held through reset block the first grants
		rdLoad = 2'b11;
		wrCfg[0] = makeCfg(WIN0, 32, BURST);
		wrCfg[1] = makeCfg(WIN1, 32, BURST);
		rdCfg[0] = makeCfg(WIN0, 32, 0); // Read ports parked
		rdCfg[1] = makeCfg(WIN1, 32, 0);
		loadModel(0, wrCfg[0]);
		loadModel(1, wrCfg[1]);
		repeat (3) @(posedge CLK);
		RESET_N <= 1'b1;
		@(posedge CLK);
		wrLoad <= '0;
		rdLoad <= '0;

		// 6 bursts per port over a 4-burst window so both wrap
		testName = "write";
		exchange(48, 48, 0, 0);
		waitIdle();
		checkMemory();

		testName = "read";
		@(posedge CLK);
		rdCfg[0] <= makeCfg(WIN0, 32, BURST);
		rdCfg[1] <= makeCfg(WIN1, 32, BURST);
		rdLoad <= 2'b11;
		@(posedge CLK);
		rdLoad <= '0;
		loadModel(2, makeCfg(WIN0, 32, BURST));
		loadModel(3, makeCfg(WIN1, 32, BURST));
		exchange(0, 0, 40, 40);
		waitIdle(); // Read FIFOs refilled

		// wr0 moves while the rd1 load holds off grants until wr0 and rd0 are both eligible
		testName = "priority";
		@(posedge CLK);
		wrCfg[0] <= makeCfg(RELOAD_START, 16, BURST);
		wrLoad <= 2'b01;
		rdLoad <= 2'b10;
		@(posedge CLK);
		wrLoad <= '0;
		loadModel(0, makeCfg(RELOAD_START, 16, BURST));
		exchange(8, 0, 8, 0);
		@(posedge CLK);
		rdLoad <= '0;
		loadModel(3, rdCfg[1]);
		do
			@(negedge CLK);
		while (pins.cmd != sdramPkg::ACTIVE);
		if ({pins.bank, pins.addr} != RELOAD_START[`ASIZE-1:`COLW])
		begin
			$display("ERROR %s: expected bank/row %h, actual %h", testName,
				RELOAD_START[`ASIZE-1:`COLW], {pins.bank, pins.addr});
			errors++;
		end

		testName = "reload";
		exchange(8, 0, 8, 8);
		waitIdle();
		checkMemory();

		$display("Read words %0d, memory words %0d, errors %0d", rdChecked, memChecked, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/sdramPkg.sv
hdl/portFifo.sv
hdl/burstAddress.sv
hdl/burstControl.sv
hdl/sdramPhy.sv
hdl/sdramPortCtrl.sv
dv/sdramModel.sv
dv/tbSdramPortCtrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SDRAM port controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbSdramPortCtrl \
	-f list.f -o simv
./obj_dir/simv | tee sim.log

# Pass only if the testbench reported a clean run
grep -q "No errors" sim.log
